//--- rtl/cpuPkg.sv
package cpuPkg;

    //////////////////////////////////////////////////
    // Widths and base types
    //////////////////////////////////////////////////

    // Data, bus addresses and ROM words share one width
    localparam int dataWidth = 8;

    typedef logic [dataWidth-1:0] dataT;

    //////////////////////////////////////////////////
    // Instruction encoding
    //////////////////////////////////////////////////

    // Low nibble of the instruction byte
    // Odd opcodes of the first three pairs target register B
    typedef enum logic [3:0] {
        readA     = 4'h0,
        readB     = 4'h1,
        writeA    = 4'h2,
        writeB    = 4'h3,
        mathsA    = 4'h4,
        mathsB    = 4'h5,
        branch    = 4'h6,
        gotoAddr  = 4'h7,
        endThread = 4'h8
    } opcodeT;

    // High nibble selects the ALU function
    // Codes 9 to B double as the branch condition
    typedef enum logic [3:0] {
        add         = 4'h0,
        sub         = 4'h1,
        mul         = 4'h2,
        shiftLeftA  = 4'h3,
        shiftRightA = 4'h4,
        incA        = 4'h5,
        incB        = 4'h6,
        decA        = 4'h7,
        decB        = 4'h8,
        equal       = 4'h9,
        greater     = 4'hA,
        less        = 4'hB
    } aluOpT;

    // Bit positions inside the ALU flag vector
    localparam int flagEqual   = 0;
    localparam int flagGreater = 1;
    localparam int flagLess    = 2;

    //////////////////////////////////////////////////
    // Datapath commands from the control FSM
    //////////////////////////////////////////////////

    typedef enum logic [2:0] {
        pcHold,
        pcInc1,
        pcInc2,
        pcLoadRom,
        pcVectorA,
        pcVectorB
    } pcCmdT;

    typedef enum logic [2:0] {
        regNone,
        regLoadBusA,
        regLoadBusB,
        regLoadAluA,
        regLoadAluB
    } regCmdT;

    typedef enum logic [1:0] {
        busIdle,
        busReadRom,
        busWriteA,
        busWriteB
    } busCmdT;

    //////////////////////////////////////////////////
    // Fixed addresses
    //////////////////////////////////////////////////

    // ROM locations holding the thread start address per interrupt
    localparam dataT vectorA = 8'hFF;
    localparam dataT vectorB = 8'hFE;

    // Address on the bus when nothing is transferred
    localparam dataT busIdleAddr = 8'hFF;

endpackage

//--- rtl/alu.sv
`timescale 1ns/1ps

module alu (
    input  cpuPkg::dataT   regA,
    input  cpuPkg::dataT   regB,
    input  cpuPkg::aluOpT  aluOp,
    output cpuPkg::dataT   aluResult,
    output logic [2:0]     aluFlags
);

    import cpuPkg::*;

    //////////////////////////////////////////////////
    // Comparison flags
    //////////////////////////////////////////////////

    // Unsigned compares, used by branches and by codes 9 to B
    assign aluFlags[flagEqual]   = (regA == regB);
    assign aluFlags[flagGreater] = (regA > regB);
    assign aluFlags[flagLess]    = (regA < regB);

    //////////////////////////////////////////////////
    // Result
    //////////////////////////////////////////////////

    always_comb begin
        case (aluOp)
            add:         aluResult = regA + regB;
            sub:         aluResult = regA - regB;
            // Low byte of the product
            mul:         aluResult = regA * regB;
            shiftLeftA:  aluResult = regA << 1;
            shiftRightA: aluResult = regA >> 1;
            incA:        aluResult = regA + dataT'(1);
            incB:        aluResult = regB + dataT'(1);
            decA:        aluResult = regA - dataT'(1);
            decB:        aluResult = regB - dataT'(1);
            // Compares return 1 or 0
            equal:       aluResult = dataT'(aluFlags[flagEqual]);
            greater:     aluResult = dataT'(aluFlags[flagGreater]);
            less:        aluResult = dataT'(aluFlags[flagLess]);
            // Unused codes pass A through
            default:     aluResult = regA;
        endcase
    end

endmodule

//--- rtl/busPort.sv
`timescale 1ns/1ps

module busPort (
    input  logic            CLK,
    input  logic            RESET,
    input  cpuPkg::busCmdT  busCmd,
    input  cpuPkg::dataT    romData,
    input  cpuPkg::dataT    regA,
    input  cpuPkg::dataT    regB,
    output cpuPkg::dataT    busAddr,
    output cpuPkg::dataT    busDataOut,
    output logic            busWe
);

    import cpuPkg::*;

    //////////////////////////////////////////////////
    // Address and write strobe
    //////////////////////////////////////////////////

    // Address comes from the operand byte, else parks at idle
    always_ff @(posedge CLK) begin
        if (RESET) begin
            busAddr <= busIdleAddr;
            busWe   <= 1'b0;
        end else begin
            busAddr <= (busCmd == busIdle) ? busIdleAddr : romData;
            // One strobe per write command
            busWe   <= (busCmd == busWriteA) || (busCmd == busWriteB);
        end
    end

    // Write data, held between writes
    always_ff @(posedge CLK) begin
        case (busCmd)
            busWriteA: busDataOut <= regA;
            busWriteB: busDataOut <= regB;
            default:   busDataOut <= busDataOut;
        endcase
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    // A write always carries a real address
    assert property (@(posedge CLK) disable iff (RESET)
        busWe |-> busAddr != busIdleAddr);

endmodule

//--- rtl/progCounter.sv
`timescale 1ns/1ps

module progCounter (
    input  logic           CLK,
    input  logic           RESET,
    input  cpuPkg::pcCmdT  pcCmd,
    input  logic           offsetNext,
    input  cpuPkg::dataT   romData,
    output cpuPkg::dataT   romAddress
);

    import cpuPkg::*;

    dataT  pc;
    // Selects the operand byte after the opcode
    logic  offset;

    // ROM sees pc plus the fetch offset
    assign romAddress = pc + dataT'(offset);

    //////////////////////////////////////////////////
    // Program counter
    //////////////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (RESET) begin
            pc <= '0;
        end else begin
            case (pcCmd)
                pcInc1: begin
                    pc <= pc + dataT'(1);
                end
                // Skip opcode and operand
                pcInc2: begin
                    pc <= pc + dataT'(2);
                end
                // Jump target or thread start from the ROM
                pcLoadRom: begin
                    pc <= romData;
                end
                pcVectorA: begin
                    pc <= vectorA;
                end
                pcVectorB: begin
                    pc <= vectorB;
                end
                default: begin
                    pc <= pc;
                end
            endcase
        end
    end

    // Offset lasts one cycle only
    always_ff @(posedge CLK) begin
        if (RESET) begin
            offset <= 1'b0;
        end else begin
            offset <= offsetNext;
        end
    end

endmodule

//--- rtl/registerFile.sv
`timescale 1ns/1ps

module registerFile (
    input  logic            CLK,
    input  logic            RESET,
    input  cpuPkg::regCmdT  regCmd,
    input  cpuPkg::dataT    busDataIn,
    input  cpuPkg::dataT    aluResult,
    output cpuPkg::dataT    regA,
    output cpuPkg::dataT    regB
);

    import cpuPkg::*;

    //////////////////////////////////////////////////
    // Registers A and B
    //////////////////////////////////////////////////

    // A loads from the bus or the ALU
    always_ff @(posedge CLK) begin
        if (RESET) begin
            regA <= '0;
        end else begin
            case (regCmd)
                regLoadBusA: regA <= busDataIn;
                regLoadAluA: regA <= aluResult;
                default:     regA <= regA;
            endcase
        end
    end

    // B mirrors A
    always_ff @(posedge CLK) begin
        if (RESET) begin
            regB <= '0;
        end else begin
            case (regCmd)
                regLoadBusB: regB <= busDataIn;
                regLoadAluB: regB <= aluResult;
                default:     regB <= regB;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    // Control FSM must always drive a defined command
    assert property (@(posedge CLK) disable iff (RESET)
        !$isunknown(regCmd));

endmodule

//--- rtl/cpuControl.sv
`timescale 1ns/1ps

module cpuControl (
    input  logic            CLK,
    input  logic            RESET,
    input  cpuPkg::dataT    romData,
    input  logic [2:0]      aluFlags,
    input  logic [1:0]      busInterruptsRaise,
    output cpuPkg::pcCmdT   pcCmd,
    output logic            offsetNext,
    output cpuPkg::regCmdT  regCmd,
    output cpuPkg::busCmdT  busCmd,
    output logic [1:0]      busInterruptsAck
);

    import cpuPkg::*;

    //////////////////////////////////////////////////
    // State encoding
    //////////////////////////////////////////////////

    // One short chain of wait states per instruction
    typedef enum logic [4:0] {
        sIdle,
        sThread0,
        sThread1,
        sThread2,
        sDecode,
        sReadWait,
        sReadAddr,
        sReadInc,
        sReadLoad,
        sWriteInc,
        sWriteOut,
        sMaths,
        sMathsWait,
        sBranchCond,
        sBranchEval,
        sBranchWait,
        sGoto,
        sGotoLoad,
        sGotoWait
    } stateT;

    stateT       state, stateNext;
    // Low opcode bit picks register B over A
    logic        regSelect, regSelectNext;
    // Branch condition, taken from the instruction byte
    aluOpT       cond, condNext;
    logic [1:0]  ackReg, ackNext;
    logic        taken;

    assign busInterruptsAck = ackReg;

    //////////////////////////////////////////////////
    // State registers
    //////////////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state     <= sDecode;
            regSelect <= 1'b0;
            cond      <= add;
            ackReg    <= 2'b00;
        end else begin
            state     <= stateNext;
            regSelect <= regSelectNext;
            cond      <= condNext;
            ackReg    <= ackNext;
        end
    end

    // Branch test against the live comparison flags
    // Unknown condition codes never take the branch
    always_comb begin
        case (cond)
            equal:   taken = aluFlags[flagEqual];
            greater: taken = aluFlags[flagGreater];
            less:    taken = aluFlags[flagLess];
            default: taken = 1'b0;
        endcase
    end

    //////////////////////////////////////////////////
    // Next state and datapath commands
    //////////////////////////////////////////////////

    always_comb begin
        // Defaults: hold everything, issue nothing
        stateNext     = state;
        regSelectNext = regSelect;
        condNext      = cond;
        ackNext       = 2'b00;
        pcCmd         = pcHold;
        offsetNext    = 1'b0;
        regCmd        = regNone;
        busCmd        = busIdle;

        case (state)
            // Sleep until an interrupt, line 0 wins
            sIdle: begin
                if (busInterruptsRaise[0]) begin
                    stateNext = sThread0;
                    pcCmd     = pcVectorA;
                    ackNext   = 2'b01;
                end else if (busInterruptsRaise[1]) begin
                    stateNext = sThread0;
                    pcCmd     = pcVectorB;
                    ackNext   = 2'b10;
                end
            end
            // Vector address goes out to the ROM
            sThread0: stateNext = sThread1;
            // Start address is on romData now
            sThread1: begin
                stateNext = sThread2;
                pcCmd     = pcLoadRom;
            end
            // New pc reaches the ROM
            sThread2: stateNext = sDecode;

            sDecode: begin
                // Point at the operand byte for the next cycle
                offsetNext    = 1'b1;
                regSelectNext = romData[0];
                case (opcodeT'(romData[3:0]))
                    readA, readB:   stateNext = sReadWait;
                    writeA, writeB: stateNext = sWriteInc;
                    mathsA, mathsB: stateNext = sMaths;
                    branch:         stateNext = sBranchCond;
                    gotoAddr:       stateNext = sGoto;
                    // endThread and every unused opcode
                    default:        stateNext = sIdle;
                endcase
            end

            // Memory read, operand byte still in flight
            sReadWait: stateNext = sReadAddr;
            sReadAddr: begin
                stateNext = sReadInc;
                busCmd    = busReadRom;
            end
            // Step pc early so the next opcode is ready at decode
            sReadInc: begin
                stateNext = sReadLoad;
                pcCmd     = pcInc2;
            end
            sReadLoad: begin
                stateNext = sDecode;
                regCmd    = regSelect ? regLoadBusB : regLoadBusA;
            end

            // Memory write
            sWriteInc: begin
                stateNext = sWriteOut;
                pcCmd     = pcInc2;
            end
            sWriteOut: begin
                stateNext = sDecode;
                busCmd    = regSelect ? busWriteB : busWriteA;
            end

            // ALU op code is still on romData here
            sMaths: begin
                stateNext = sMathsWait;
                pcCmd     = pcInc1;
                regCmd    = regSelect ? regLoadAluB : regLoadAluA;
            end
            sMathsWait: stateNext = sDecode;

            // Conditional branch
            sBranchCond: begin
                stateNext = sBranchEval;
                condNext  = aluOpT'(romData[7:4]);
            end
            sBranchEval: begin
                stateNext = sBranchWait;
                pcCmd     = taken ? pcLoadRom : pcInc2;
            end
            sBranchWait: stateNext = sDecode;

            // Unconditional jump
            sGoto: stateNext = sGotoLoad;
            sGotoLoad: begin
                stateNext = sGotoWait;
                pcCmd     = pcLoadRom;
            end
            sGotoWait: stateNext = sDecode;

            default: stateNext = sIdle;
        endcase
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    // Only one interrupt is served per wake-up
    assert property (@(posedge CLK) disable iff (RESET)
        busInterruptsAck != 2'b11);

    // Idle never advances the program
    assert property (@(posedge CLK) disable iff (RESET)
        state == sIdle |-> pcCmd != pcInc2);

endmodule

//--- rtl/processor.sv
`timescale 1ns/1ps

module processor (
    input  logic          CLK,
    input  logic          RESET,
    output cpuPkg::dataT  romAddress,
    input  cpuPkg::dataT  romData,
    output cpuPkg::dataT  busAddr,
    input  cpuPkg::dataT  busDataIn,
    output cpuPkg::dataT  busDataOut,
    output logic          busWe,
    input  logic [1:0]    busInterruptsRaise,
    output logic [1:0]    busInterruptsAck
);

    import cpuPkg::*;

    // Commands from control to datapath
    pcCmdT       pcCmd;
    logic        offsetNext;
    regCmdT      regCmd;
    busCmdT      busCmd;

    // Datapath values
    dataT        regA, regB;
    dataT        aluResult;
    logic [2:0]  aluFlags;

    //////////////////////////////////////////////////
    // Control
    //////////////////////////////////////////////////

    cpuControl control (
        .CLK(CLK),
        .RESET(RESET),
        .romData(romData),
        .aluFlags(aluFlags),
        .busInterruptsRaise(busInterruptsRaise),
        .pcCmd(pcCmd),
        .offsetNext(offsetNext),
        .regCmd(regCmd),
        .busCmd(busCmd),
        .busInterruptsAck(busInterruptsAck)
    );

    //////////////////////////////////////////////////
    // Datapath
    //////////////////////////////////////////////////

    progCounter pcUnit (
        .CLK(CLK),
        .RESET(RESET),
        .pcCmd(pcCmd),
        .offsetNext(offsetNext),
        .romData(romData),
        .romAddress(romAddress)
    );

    registerFile regs (
        .CLK(CLK),
        .RESET(RESET),
        .regCmd(regCmd),
        .busDataIn(busDataIn),
        .aluResult(aluResult),
        .regA(regA),
        .regB(regB)
    );

    // Op code is the high nibble of the current ROM byte
    alu aluUnit (
        .regA(regA),
        .regB(regB),
        .aluOp(aluOpT'(romData[7:4])),
        .aluResult(aluResult),
        .aluFlags(aluFlags)
    );

    busPort bus (
        .CLK(CLK),
        .RESET(RESET),
        .busCmd(busCmd),
        .romData(romData),
        .regA(regA),
        .regB(regB),
        .busAddr(busAddr),
        .busDataOut(busDataOut),
        .busWe(busWe)
    );

endmodule

//--- sim/tbTests.svh
`ifndef TB_TESTS_SVH
`define TB_TESTS_SVH

    //////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////

    task automatic checkData(input dataT actual, input dataT expected, input string what);
        if (actual !== expected) begin
            errorCount++;
            $display("[ERROR] %0t: %s is %02h, expected %02h", $time, what, actual, expected);
        end
    endtask

    task automatic checkAck(input logic [1:0] actual, input logic [1:0] expected,
                            input string what);
        if (actual !== expected) begin
            errorCount++;
            $display("[ERROR] %0t: %s is %02b, expected %02b", $time, what, actual, expected);
        end
    endtask

    // One logged write against address and value
    task automatic checkWrite(input int index, input dataT addr, input dataT value,
                              input string what);
        if (index >= writeAddrLog.size()) begin
            errorCount++;
            $display("No bus write was seen for %s", what);
        end else begin
            checkData(writeAddrLog[index], addr, {what, " address"});
            checkData(writeDataLog[index], value, {what, " data"});
        end
    endtask

    //////////////////////////////////////////////////
    // Reference model and program builder
    //////////////////////////////////////////////////

    // ALU result straight from the operation table
    function automatic dataT predictAlu(input logic [3:0] op, input dataT a, input dataT b);
        logic [15:0] product;
        product = {8'h00, a} * {8'h00, b};
        case (op)
            4'h0: return a + b;
            4'h1: return a - b;
            4'h2: return product[7:0];
            4'h3: return {a[6:0], 1'b0};
            4'h4: return {1'b0, a[7:1]};
            4'h5: return a + 8'd1;
            4'h6: return b + 8'd1;
            4'h7: return a - 8'd1;
            4'h8: return b - 8'd1;
            4'h9: return (a == b) ? 8'd1 : 8'd0;
            4'hA: return (a > b) ? 8'd1 : 8'd0;
            4'hB: return (a < b) ? 8'd1 : 8'd0;
            default: return a;
        endcase
    endfunction

    dataT progPtr;

    // Low nibble 8 everywhere makes a stray fetch end the thread
    // Data words rotate the address and flip a few bits
    task automatic fillMemories();
        for (int i = 0; i < 256; i++) begin
            rom[i] = {4'(i >> 4) ^ 4'(i), 4'h8};
            dataMem[i] = {dataT'(i) << 3 | dataT'(i) >> 5} ^ 8'hA5;
        end
    endtask

    task automatic emit(input dataT value);
        rom[progPtr] = value;
        progPtr = progPtr + 8'd1;
    endtask

    task automatic emitRead(input logic toB, input dataT addr);
        emit(toB ? 8'h01 : 8'h00);
        emit(addr);
    endtask

    task automatic emitWrite(input logic fromB, input dataT addr);
        emit(fromB ? 8'h03 : 8'h02);
        emit(addr);
    endtask

    task automatic emitMaths(input logic [3:0] op, input logic toB);
        emit({op, toB ? 4'h5 : 4'h4});
    endtask

    task automatic emitBranch(input logic [3:0] cond, input dataT target);
        emit({cond, 4'h6});
        emit(target);
    endtask

    task automatic emitGoto(input dataT target);
        emit(8'h07);
        emit(target);
    endtask

    task automatic emitEnd();
        emit(8'h08);
    endtask

    //////////////////////////////////////////////////
    // Thread runner
    //////////////////////////////////////////////////

    // Wake the CPU, check the ack pulse, wait for the thread's writes
    task automatic runThread(input logic [1:0] lines, input logic [1:0] ackExpected,
                             input int writes, output int base);
        base = writeAddrLog.size();
        @(posedge CLK);
        #1;
        busInterruptsRaise = lines;
        @(negedge CLK);
        while (busInterruptsAck == 2'b00) @(negedge CLK);
        checkAck(busInterruptsAck, ackExpected, "acknowledge");
        @(posedge CLK);
        #1;
        busInterruptsRaise = 2'b00;
        // Pulse is one cycle wide
        @(negedge CLK);
        checkAck(busInterruptsAck, 2'b00, "acknowledge after pulse");
        while (writeAddrLog.size() < base + writes) @(negedge CLK);
        // Last write shares its cycle with the endThread decode
        repeat (4) @(negedge CLK);
        if (writeAddrLog.size() != base + writes) begin
            errorCount++;
            $display("[ERROR] %0t: %0d bus writes in thread, expected %0d",
                     $time, writeAddrLog.size() - base, writes);
        end
    endtask

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////

    task automatic testResetWake();
        int base;
        @(negedge CLK);
        checkData(dataT'(busWe), 8'h00, "busWe after reset");
        checkData(busAddr, 8'hFF, "busAddr after reset");
        checkData(romAddress, 8'h00, "romAddress after reset");
        // Each thread writes its own constant
        dataMem[8'h80] = 8'hA0;
        dataMem[8'h81] = 8'hB1;
        rom[8'hFF] = 8'h10;
        rom[8'hFE] = 8'h40;
        progPtr = 8'h10;
        emitRead(1'b0, 8'h80);
        emitWrite(1'b0, 8'hE0);
        emitEnd();
        progPtr = 8'h40;
        emitRead(1'b1, 8'h81);
        emitWrite(1'b1, 8'hE1);
        emitEnd();
        // Line 0 wins over line 1
        runThread(2'b11, 2'b01, 1, base);
        checkWrite(base, 8'hE0, 8'hA0, "thread 0 marker");
        runThread(2'b10, 2'b10, 1, base);
        checkWrite(base, 8'hE1, 8'hB1, "thread 1 marker");
    endtask

    task automatic testReadWrite();
        dataT a;
        dataT b;
        int base;
        a = dataT'($urandom);
        b = dataT'($urandom);
        dataMem[8'h90] = a;
        dataMem[8'h91] = b;
        rom[8'hFF] = 8'h10;
        progPtr = 8'h10;
        emitRead(1'b0, 8'h90);
        emitRead(1'b1, 8'h91);
        emitWrite(1'b0, 8'hA0);
        emitWrite(1'b1, 8'hA1);
        emitWrite(1'b1, 8'hA2);
        emitWrite(1'b0, 8'hA3);
        emitEnd();
        runThread(2'b01, 2'b01, 4, base);
        checkWrite(base, 8'hA0, a, "write of A");
        checkWrite(base + 1, 8'hA1, b, "write of B");
        checkWrite(base + 2, 8'hA2, b, "second write of B");
        checkWrite(base + 3, 8'hA3, a, "second write of A");
    endtask

    // Every 4-bit code with even codes into A and odd ones into B
    task automatic testAlu();
        logic [3:0] code;
        dataT a;
        dataT b;
        int base;
        for (int op = 0; op < 16; op++) begin
            code = 4'(op);
            a = dataT'($urandom);
            b = dataT'($urandom);
            dataMem[8'h90] = a;
            dataMem[8'h91] = b;
            rom[8'hFF] = 8'h10;
            progPtr = 8'h10;
            emitRead(1'b0, 8'h90);
            emitRead(1'b1, 8'h91);
            emitMaths(code, code[0]);
            emitWrite(code[0], 8'hC0);
            emitEnd();
            runThread(2'b01, 2'b01, 1, base);
            checkWrite(base, 8'hC0, predictAlu(code, a, b),
                       $sformatf("ALU code %0h", code));
        end
    endtask

    // Each condition once true and once false
    task automatic testBranches();
        logic [3:0] cond;
        dataT hi;
        dataT lo;
        dataT tmp;
        dataT a;
        dataT b;
        logic expectTaken;
        int base;
        dataMem[8'h92] = 8'd1;
        dataMem[8'h93] = 8'd2;
        for (int c = 0; c < 3; c++) begin
            for (int t = 0; t < 2; t++) begin
                cond = 4'h9 + 4'(c);
                hi = dataT'($urandom);
                lo = dataT'($urandom);
                if (hi == lo) lo = hi + 8'd1;
                if (hi < lo) begin
                    tmp = hi;
                    hi = lo;
                    lo = tmp;
                end
                // t == 0 picks a pair that meets the condition
                case (cond)
                    4'h9: begin
                        a = hi;
                        b = (t == 0) ? hi : lo;
                    end
                    4'hA: begin
                        a = (t == 0) ? hi : lo;
                        b = (t == 0) ? lo : hi;
                    end
                    default: begin
                        a = (t == 0) ? lo : hi;
                        b = (t == 0) ? hi : lo;
                    end
                endcase
                case (cond)
                    4'h9: expectTaken = (a == b);
                    4'hA: expectTaken = (a > b);
                    default: expectTaken = (a < b);
                endcase
                dataMem[8'h90] = a;
                dataMem[8'h91] = b;
                rom[8'hFF] = 8'h10;
                progPtr = 8'h10;
                emitRead(1'b0, 8'h90);
                emitRead(1'b1, 8'h91);
                // Taken path starts 11 bytes into the program
                emitBranch(cond, 8'h1B);
                emitRead(1'b0, 8'h93);
                emitWrite(1'b0, 8'hD0);
                emitEnd();
                emitRead(1'b0, 8'h92);
                emitWrite(1'b0, 8'hD0);
                emitEnd();
                runThread(2'b01, 2'b01, 1, base);
                checkWrite(base, 8'hD0, expectTaken ? 8'd1 : 8'd2,
                           $sformatf("branch code %0h marker", cond));
            end
        end
    endtask

    task automatic testGotoEnd();
        dataT v;
        int base;
        v = dataT'($urandom);
        dataMem[8'h94] = v;
        rom[8'hFF] = 8'h10;
        rom[8'hFE] = 8'h10;
        progPtr = 8'h10;
        emitRead(1'b0, 8'h94);
        emitGoto(8'h16);
        // Skipped so D8 must never be written
        emitWrite(1'b0, 8'hD8);
        emitWrite(1'b0, 8'hD4);
        emitEnd();
        runThread(2'b01, 2'b01, 1, base);
        checkWrite(base, 8'hD4, v, "write after goto");
        // Back in idle so line 1 is served again
        runThread(2'b10, 2'b10, 1, base);
        checkWrite(base, 8'hD4, v, "write after second wake-up");
    endtask

`endif

//--- sim/tbProcessor.sv
`timescale 1ns/1ps

module tbProcessor;

    import cpuPkg::*;

    //////////////////////////////////////////////////
    // Run limits
    //////////////////////////////////////////////////

    localparam int resetCycles = 8;
    // Wake-ups over all tests add up as 2 + 1 + 16 + 6 + 2
    localparam int threadCount = 27;
    // Longest thread is about 40 cycles plus settle time and slack
    localparam int cyclesPerThread = 140;
    // Reset and start-up margin on top
    localparam int timeoutCycles = threadCount * cyclesPerThread + 220;

    //////////////////////////////////////////////////
    // DUT signals
    //////////////////////////////////////////////////

    logic        CLK;
    logic        RESET;
    dataT        romAddress;
    dataT        romData = '0;
    dataT        busAddr;
    dataT        busDataIn = '0;
    dataT        busDataOut;
    logic        busWe;
    logic [1:0]  busInterruptsRaise;
    logic [1:0]  busInterruptsAck;

    // Program ROM and data memory images
    dataT        rom [256];
    dataT        dataMem [256];
    dataT        romSample;
    dataT        memSample;

    // Every bus write in order of arrival
    dataT        writeAddrLog [$];
    dataT        writeDataLog [$];

    int          errorCount;
    int          cycleCount = 0;

    processor dut (
        .CLK(CLK),
        .RESET(RESET),
        .romAddress(romAddress),
        .romData(romData),
        .busAddr(busAddr),
        .busDataIn(busDataIn),
        .busDataOut(busDataOut),
        .busWe(busWe),
        .busInterruptsRaise(busInterruptsRaise),
        .busInterruptsAck(busInterruptsAck)
    );

    // 20 ns period
    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    //////////////////////////////////////////////////
    // Memory models
    //////////////////////////////////////////////////

    // ROM answers one cycle after the address
    always @(posedge CLK) begin
        romSample = rom[romAddress];
        #1;
        romData = romSample;
    end

    // Data memory reads one cycle late and logs each write it takes
    always @(posedge CLK) begin
        memSample = dataMem[busAddr];
        if (busWe) begin
            dataMem[busAddr] = busDataOut;
            writeAddrLog.push_back(busAddr);
            writeDataLog.push_back(busDataOut);
        end
        #1;
        busDataIn = memSample;
    end

    // Abort a run that stops making progress
    always @(posedge CLK) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("Timeout: tests did not finish within %0d cycles", timeoutCycles);
            $display("Test FAILED");
            $finish;
        end
    end

    `include "tbTests.svh"

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        errorCount = 0;
        RESET = 1'b1;
        busInterruptsRaise = 2'b00;
        void'($urandom(32'hc163_1080));
        fillMemories();

        repeat (resetCycles) @(posedge CLK);
        #1;
        RESET = 1'b0;

        testResetWake();
        testReadWrite();
        testAlu();
        testBranches();
        testGotoEnd();

        $display("Errors: %0d", errorCount);
        if (errorCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+sim
rtl/cpuPkg.sv
rtl/alu.sv
rtl/busPort.sv
rtl/progCounter.sv
rtl/registerFile.sv
rtl/cpuControl.sv
rtl/processor.sv
sim/tbProcessor.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tbProcessor
FILELIST  = compile.f
OBJDIR    = obj_dir
BIN       = $(OBJDIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(wildcard rtl/*.sv) $(wildcard sim/*.sv) $(wildcard sim/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "Test OK" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)
